//--- eth_frame_pkg.sv
package eth_frame_pkg;

    ////////////////////////////////////////////////////////////
    // line and frame types
    ////////////////////////////////////////////////////////////

    typedef logic [7:0]  byte_t;
    // station address, msb byte goes out first
    typedef logic [47:0] mac_addr_t;
    typedef logic [31:0] fcs_t;
    typedef logic [15:0] len_t;

    ////////////////////////////////////////////////////////////
    // frame layout
    ////////////////////////////////////////////////////////////

    // seven fill bytes plus the delimiter
    localparam int    preamble_len    = 8;
    localparam byte_t preamble_byte   = 8'h55;
    localparam byte_t sfd_byte        = 8'hD5;
    localparam int    mac_addr_len    = 6;
    localparam int    type_len        = 2;
    localparam int    min_payload_len = 46;
    localparam int    fcs_len         = 4;
    localparam int    ifg_len         = 12;

    ////////////////////////////////////////////////////////////
    // crc-32
    ////////////////////////////////////////////////////////////

    localparam fcs_t crc_init = 32'hFFFF_FFFF;
    // 04C11DB7h, bit reversed for lsb-first shifting
    localparam fcs_t crc_poly_refl = 32'hEDB8_8320;

    // one byte of the reflected crc, lsb first
    function automatic fcs_t crc32_byte(input fcs_t crc, input byte_t data);
        fcs_t c;
        c = crc ^ {24'h0, data};
        for (int i = 0; i < 8; i++) begin
            if (c[0]) begin
                c = (c >> 1) ^ crc_poly_refl;
            end else begin
                c = c >> 1;
            end
        end
        return c;
    endfunction

endpackage

//--- tx_ctrl_pkg.sv
package tx_ctrl_pkg;

    ////////////////////////////////////////////////////////////
    // framer FSM
    ////////////////////////////////////////////////////////////

    typedef enum logic [3:0] {
        idle,
        preamble,
        dst_addr,
        src_addr,
        type_len,
        payload,
        pad,
        fcs_wait,
        gap
    } framer_state_t;

    // what the fcs stage does with a byte
    typedef enum logic [1:0] {
        tag_pre,        // preamble and sfd, reloads the crc
        tag_body,       // covered by the crc
        tag_body_last,  // last covered byte, fcs comes next
        tag_abort       // byte sent with tx_er
    } byte_tag_t;

endpackage

//--- tx_framer.sv
module tx_framer
    import eth_frame_pkg::*;
    import tx_ctrl_pkg::*;
#(
    parameter mac_addr_t src_mac_addr = 48'h02DE_ADBE_EF01,
    parameter mac_addr_t dst_mac_addr = 48'hFFFF_FFFF_FFFF
) (
    input  logic      clk,
    input  logic      resetn,

    input  logic      tx_tvalid,
    input  logic      tx_tlast,
    input  byte_t     tx_tdata,
    output logic      tx_tready,

    output logic      fr_valid,
    output byte_t     fr_data,
    output byte_tag_t fr_tag
);

    framer_state_t state;
    framer_state_t next_state;

    // position inside the current field, payload bytes in payload and pad
    len_t cnt;
    len_t next_cnt;

    logic      out_valid;
    byte_t     out_data;
    byte_tag_t out_tag;

    // address byte by index, msb first
    function automatic byte_t addr_byte(input mac_addr_t addr, input len_t idx);
        int shift;
        shift = 8 * (mac_addr_len - 1 - int'(idx));
        return byte_t'(addr >> shift);
    endfunction

    assign tx_tready = (state == tx_ctrl_pkg::type_len) || (state == payload);

    ////////////////////////////////////////////////////////////
    // next state and byte select
    ////////////////////////////////////////////////////////////

    always_comb begin
        next_state = state;
        out_valid  = 1'b0;
        out_data   = '0;
        out_tag    = tag_body;

        unique case (state)
            idle: begin
                if (tx_tvalid) begin
                    next_state = preamble;
                end
            end
            preamble: begin
                out_valid = 1'b1;
                out_tag   = tag_pre;
                out_data  = (cnt == len_t'(preamble_len - 1)) ? sfd_byte : preamble_byte;
                if (cnt == len_t'(preamble_len - 1)) begin
                    next_state = dst_addr;
                end
            end
            dst_addr: begin
                out_valid = 1'b1;
                out_data  = addr_byte(dst_mac_addr, cnt);
                if (cnt == len_t'(mac_addr_len - 1)) begin
                    next_state = src_addr;
                end
            end
            src_addr: begin
                out_valid = 1'b1;
                out_data  = addr_byte(src_mac_addr, cnt);
                if (cnt == len_t'(mac_addr_len - 1)) begin
                    next_state = tx_ctrl_pkg::type_len;
                end
            end
            tx_ctrl_pkg::type_len: begin
                out_valid = 1'b1;
                out_data  = tx_tdata;
                if (cnt == len_t'(eth_frame_pkg::type_len - 1)) begin
                    next_state = payload;
                end
            end
            payload: begin
                out_valid = 1'b1;
                out_data  = tx_tdata;
                if (tx_tlast) begin
                    // short frames continue into the zero pad
                    if (cnt >= len_t'(min_payload_len - 1)) begin
                        out_tag    = tag_body_last;
                        next_state = fcs_wait;
                    end else begin
                        next_state = pad;
                    end
                end
            end
            pad: begin
                out_valid = 1'b1;
                if (cnt == len_t'(min_payload_len - 1)) begin
                    out_tag    = tag_body_last;
                    next_state = fcs_wait;
                end
            end
            fcs_wait: begin
                // line is busy with the fcs bytes
                if (cnt == len_t'(fcs_len - 1)) begin
                    next_state = gap;
                end
            end
            gap: begin
                if (cnt == len_t'(ifg_len - 1)) begin
                    next_state = tx_tvalid ? preamble : idle;
                end
            end
            default: begin
                next_state = idle;
            end
        endcase

        // source dropped valid inside the frame
        if (!tx_tvalid && (state inside {preamble, dst_addr, src_addr,
                                         tx_ctrl_pkg::type_len, payload})) begin
            out_valid  = 1'b1;
            out_data   = '0;
            out_tag    = tag_abort;
            next_state = gap;
        end
    end

    // counter restarts on each field, except payload into pad
    always_comb begin
        if (state != idle && (next_state == state || next_state == pad)) begin
            next_cnt = cnt + len_t'(1);
        end else begin
            next_cnt = '0;
        end
    end

    ////////////////////////////////////////////////////////////
    // registers
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state    <= idle;
            cnt      <= '0;
            fr_valid <= 1'b0;
            fr_tag   <= tag_pre;
        end else begin
            state    <= next_state;
            cnt      <= next_cnt;
            fr_valid <= out_valid;
            fr_tag   <= out_tag;
        end
    end

    always_ff @(posedge clk) begin
        fr_data <= out_data;
    end

    // tready rises only once the last source address byte is done
    assert property (@(posedge clk) disable iff (!resetn)
        $rose(tx_tready) |->
            $past(state == src_addr && cnt == len_t'(mac_addr_len - 1)));

endmodule

//--- fcs_inserter.sv
module fcs_inserter
    import eth_frame_pkg::*;
    import tx_ctrl_pkg::*;
(
    input  logic      clk,
    input  logic      resetn,

    input  logic      fr_valid,
    input  byte_t     fr_data,
    input  byte_tag_t fr_tag,

    output byte_t     txd,
    output logic      tx_en,
    output logic      tx_er
);

    // running crc, becomes the fcs shift register after the last body byte
    fcs_t crc;

    logic       fcs_active;
    logic [1:0] fcs_cnt;

    logic is_body;
    logic is_last;

    assign is_body = fr_valid && (fr_tag == tag_body || fr_tag == tag_body_last);
    assign is_last = fr_valid && (fr_tag == tag_body_last);

    ////////////////////////////////////////////////////////////
    // fcs sequencing and line control
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!resetn) begin
            fcs_active <= 1'b0;
            fcs_cnt    <= '0;
            tx_en      <= 1'b0;
            tx_er      <= 1'b0;
        end else begin
            if (fcs_active) begin
                tx_en   <= 1'b1;
                tx_er   <= 1'b0;
                fcs_cnt <= fcs_cnt + 2'd1;
                if (fcs_cnt == 2'(fcs_len - 1)) begin
                    fcs_active <= 1'b0;
                end
            end else begin
                tx_en <= fr_valid;
                tx_er <= fr_valid && (fr_tag == tag_abort);
                if (is_last) begin
                    fcs_active <= 1'b1;
                    fcs_cnt    <= '0;
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // data path
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (fcs_active) begin
            // complemented crc, low byte first
            txd <= ~crc[7:0];
            crc <= crc >> 8;
        end else begin
            txd <= fr_valid ? fr_data : '0;
            if (fr_valid && fr_tag == tag_pre) begin
                crc <= crc_init;
            end else if (is_body) begin
                crc <= crc32_byte(crc, fr_data);
            end
        end
    end

    // an error byte ends the frame, no fcs behind it
    assert property (@(posedge clk) disable iff (!resetn)
        tx_er |-> tx_en ##1 !tx_en);

    // framer stays silent while the fcs goes out
    assert property (@(posedge clk) disable iff (!resetn)
        fcs_active |-> !fr_valid);

endmodule

//--- eth_tx_mac.sv
module eth_tx_mac
    import eth_frame_pkg::*;
    import tx_ctrl_pkg::*;
#(
    parameter mac_addr_t src_mac_addr = 48'h02DE_ADBE_EF01,
    parameter mac_addr_t dst_mac_addr = 48'hFFFF_FFFF_FFFF
) (
    input  logic  clk,
    input  logic  resetn,

    // byte stream in
    input  logic  tx_tvalid,
    input  logic  tx_tlast,
    input  byte_t tx_tdata,
    output logic  tx_tready,

    // gmii-style line out
    output byte_t txd,
    output logic  tx_en,
    output logic  tx_er
);

    ////////////////////////////////////////////////////////////
    // framer to fcs stage
    ////////////////////////////////////////////////////////////

    logic      fr_valid;
    byte_t     fr_data;
    byte_tag_t fr_tag;

    tx_framer #(
        .src_mac_addr (src_mac_addr),
        .dst_mac_addr (dst_mac_addr)
    ) u_tx_framer (
        .clk       (clk),
        .resetn    (resetn),
        .tx_tvalid (tx_tvalid),
        .tx_tlast  (tx_tlast),
        .tx_tdata  (tx_tdata),
        .tx_tready (tx_tready),
        .fr_valid  (fr_valid),
        .fr_data   (fr_data),
        .fr_tag    (fr_tag)
    );

    // one cycle behind the framer
    fcs_inserter u_fcs_inserter (
        .clk      (clk),
        .resetn   (resetn),
        .fr_valid (fr_valid),
        .fr_data  (fr_data),
        .fr_tag   (fr_tag),
        .txd      (txd),
        .tx_en    (tx_en),
        .tx_er    (tx_er)
    );

endmodule

//--- tb_clock_gen.sv
module tb_clock_gen #(
    parameter int period_ns    = 100,
    parameter int reset_cycles = 5
) (
    output logic clk,
    output logic resetn
);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk = 1'b0;
        forever begin
            #(period_ns / 2) clk = ~clk;
        end
    end

    // reset released just after an edge
    initial begin
        resetn = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        #1 resetn = 1'b1;
    end

endmodule

//--- tb_eth_tx_mac.sv
module tb_eth_tx_mac
    import eth_frame_pkg::*;
;
    timeunit 1ns;
    timeprecision 1ps;

    localparam mac_addr_t dst_addr    = 48'hFFFF_FFFF_FFFF;
    localparam mac_addr_t src_addr    = 48'h02DE_ADBE_EF01;
    localparam int        header_len  = preamble_len + 2 * mac_addr_len + type_len;
    // crc register after a body and its own fcs
    localparam fcs_t      crc_residue = 32'hDEBB_20E3;

    logic  clk;
    logic  resetn;
    logic  tx_tvalid;
    logic  tx_tlast;
    byte_t tx_tdata;
    logic  tx_tready;
    byte_t txd;
    logic  tx_en;
    logic  tx_er;

    // vectors
    int          v_len[$];
    int          v_abort[$];
    logic [31:0] v_seed[$];
    logic [31:0] v_fcs[$];

    // expected and received frames
    byte_t       exp_bytes[$];
    int          exp_len[$];
    int          exp_abort[$];
    logic [31:0] exp_vfcs[$];
    byte_t       rx_bytes[$];
    logic        rx_er[$];
    int          rx_len[$];

    int          errors;
    int          checks;
    logic [31:0] idle_lfsr;

    tb_clock_gen #(.period_ns(100), .reset_cycles(5)) u_clock_gen (
        .clk    (clk),
        .resetn (resetn)
    );

    eth_tx_mac dut (
        .clk       (clk),
        .resetn    (resetn),
        .tx_tvalid (tx_tvalid),
        .tx_tlast  (tx_tlast),
        .tx_tdata  (tx_tdata),
        .tx_tready (tx_tready),
        .txd       (txd),
        .tx_en     (tx_en),
        .tx_er     (tx_er)
    );

    ////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    task automatic take_bits(inout logic [31:0] s, input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            s = lfsr_next(s);
            v = {v[30:0], s[0]};
        end
    endtask

    // bit-serial reflected crc-32
    function automatic fcs_t crc_update(input fcs_t crc, input byte_t d);
        fcs_t c;
        logic fb;
        c = crc;
        for (int i = 0; i < 8; i++) begin
            fb = c[0] ^ d[i];
            c  = c >> 1;
            if (fb) begin
                c = c ^ 32'hEDB8_8320;
            end
        end
        return c;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic report_error(input string msg);
        errors++;
        $display("%s", msg);
    endtask

    task automatic load_vectors(output bit ok);
        int          fd;
        int          n;
        string       line;
        int          len;
        int          ab;
        logic [31:0] seed;
        logic [31:0] fcs;
        ok = 1'b0;
        fd = $fopen("eth_tx_vectors.txt", "r");
        if (fd == 0) begin
            report_error("cannot open the vector file eth_tx_vectors.txt");
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (n > 1 && line.getc(0) != 8'h23) begin
                if ($sscanf(line, "%d %d %h %h", len, ab, seed, fcs) == 4) begin
                    v_len.push_back(len);
                    v_abort.push_back(ab);
                    v_seed.push_back(seed);
                    v_fcs.push_back(fcs);
                end
            end
        end
        $fclose(fd);
        ok = (v_len.size() > 0);
        if (!ok) begin
            report_error("the vector file holds no vectors");
        end
    endtask

    ////////////////////////////////////////////////////////////
    // stream driver
    ////////////////////////////////////////////////////////////

    // tready seen at the negedge means a transfer on the next edge
    task automatic wait_ready(output bit ok);
        ok = 1'b0;
        for (int i = 0; i < 100; i++) begin
            @(negedge clk);
            if (tx_tready) begin
                ok = 1'b1;
                return;
            end
        end
    endtask

    task automatic send_frame(input int idx, input int idle);
        byte_t       pl[$];
        byte_t       e[$];
        logic [31:0] s;
        logic [31:0] v;
        fcs_t        crc;
        int          len;
        int          ab;
        int          n;
        bit          ok;
        len = v_len[idx];
        ab  = v_abort[idx];
        s   = v_seed[idx];
        for (int i = 0; i < len; i++) begin
            take_bits(s, 8, v);
            pl.push_back(v[7:0]);
        end

        // expected line bytes
        for (int i = 0; i < preamble_len - 1; i++) begin
            e.push_back(preamble_byte);
        end
        e.push_back(sfd_byte);
        for (int i = mac_addr_len - 1; i >= 0; i--) begin
            e.push_back(dst_addr[8*i +: 8]);
        end
        for (int i = mac_addr_len - 1; i >= 0; i--) begin
            e.push_back(src_addr[8*i +: 8]);
        end
        e.push_back(byte_t'(len >> 8));
        e.push_back(byte_t'(len));
        foreach (pl[i]) begin
            e.push_back(pl[i]);
        end
        for (int i = len; i < min_payload_len; i++) begin
            e.push_back(8'h00);
        end
        if (ab >= 0) begin
            // frame cut at the abort byte
            while (e.size() > header_len + ab) begin
                void'(e.pop_back());
            end
            e.push_back(8'h00);
        end else begin
            crc = crc_init;
            for (int i = preamble_len; i < e.size(); i++) begin
                crc = crc_update(crc, e[i]);
            end
            crc = ~crc;
            for (int i = 0; i < fcs_len; i++) begin
                e.push_back(crc[8*i +: 8]);
            end
        end
        foreach (e[i]) begin
            exp_bytes.push_back(e[i]);
        end
        exp_len.push_back(e.size());
        exp_abort.push_back(ab);
        exp_vfcs.push_back(v_fcs[idx]);

        repeat (idle) begin
            @(posedge clk);
            #1;
        end
        n = 2 + len;
        for (int k = 0; k < n; k++) begin
            if (ab >= 0 && k == 2 + ab) begin
                tx_tvalid = 1'b0;
                tx_tlast  = 1'b0;
                @(posedge clk);
                #1;
                break;
            end
            tx_tvalid = 1'b1;
            tx_tdata  = (k < 2) ? e[preamble_len + 2 * mac_addr_len + k] : pl[k - 2];
            tx_tlast  = (k == n - 1);
            wait_ready(ok);
            if (!ok) begin
                report_error("timed out waiting for tx_tready");
                break;
            end
            @(posedge clk);
            #1;
        end
        tx_tvalid = 1'b0;
        tx_tlast  = 1'b0;
        tx_tdata  = '0;
    endtask

    ////////////////////////////////////////////////////////////
    // line monitor
    ////////////////////////////////////////////////////////////

    logic prev_en;
    logic seen_frame;
    logic tready_d1;
    logic tready_d2;
    int   gap_cnt;
    int   pos;

    initial begin
        prev_en    = 1'b0;
        seen_frame = 1'b0;
        tready_d1  = 1'b0;
        tready_d2  = 1'b0;
        gap_cnt    = 0;
        pos        = 0;
    end

    always @(negedge clk) begin
        if (resetn) begin
            if (tx_en) begin
                if (!prev_en) begin
                    if (seen_frame && gap_cnt < ifg_len) begin
                        report_error($sformatf("gap of %0d cycles between frames is too short",
                                               gap_cnt));
                    end
                    pos = 0;
                end
                // line lags the framer by two cycles
                if (pos < preamble_len + 2 * mac_addr_len && tready_d2) begin
                    report_error("tx_tready was high while preamble or address bytes went out");
                end
                rx_bytes.push_back(txd);
                rx_er.push_back(tx_er);
                pos++;
            end else begin
                if (prev_en) begin
                    rx_len.push_back(pos);
                    seen_frame = 1'b1;
                    gap_cnt    = 0;
                end
                gap_cnt++;
            end
            prev_en   = tx_en;
            tready_d2 = tready_d1;
            tready_d1 = tx_tready;
        end
    end

    ////////////////////////////////////////////////////////////
    // frame checker
    ////////////////////////////////////////////////////////////

    task automatic check_frames(input int count);
        byte_t b[$];
        logic  er[$];
        int    glen;
        int    elen;
        int    ab;
        logic [31:0] vfcs;
        fcs_t  crc;
        bit    got;
        bit    bad;
        for (int f = 0; f < count; f++) begin
            got = 1'b0;
            for (int t = 0; t < 4000; t++) begin
                if (rx_len.size() > 0) begin
                    got = 1'b1;
                    break;
                end
                @(negedge clk);
            end
            if (!got) begin
                report_error("timed out waiting for a frame on the line");
                return;
            end
            if (exp_len.size() == 0) begin
                report_error("a frame appeared on the line that was never sent");
                return;
            end
            glen = rx_len.pop_front();
            elen = exp_len.pop_front();
            ab   = exp_abort.pop_front();
            vfcs = exp_vfcs.pop_front();
            b.delete();
            er.delete();
            for (int i = 0; i < glen; i++) begin
                b.push_back(rx_bytes.pop_front());
                er.push_back(rx_er.pop_front());
            end
            check_value("frame_len", glen, elen);
            bad = 1'b0;
            for (int i = 0; i < elen; i++) begin
                if (ab >= 0 && i == elen - 1) begin
                    if (i < glen) begin
                        check_value("tx_er", 32'(er[i]), 32'h1);
                    end
                end else if (i < glen && !bad) begin
                    check_value("txd", 32'(b[i]), 32'(exp_bytes[i]));
                    check_value("tx_er", 32'(er[i]), 32'h0);
                    bad = (b[i] !== exp_bytes[i]) || er[i];
                end
            end
            for (int i = 0; i < elen; i++) begin
                void'(exp_bytes.pop_front());
            end
            if (ab < 0 && glen == elen) begin
                crc = crc_init;
                for (int i = preamble_len; i < glen; i++) begin
                    crc = crc_update(crc, b[i]);
                end
                check_value("fcs_residue", crc, crc_residue);
                // zero in the vector file means no recorded value
                if (vfcs != 0) begin
                    check_value("fcs", {b[glen-1], b[glen-2], b[glen-3], b[glen-4]}, vfcs);
                end
            end
        end
    endtask

    ////////////////////////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////////////////////////

    initial begin
        int          e0;
        int          n_plain;
        bit          ok;
        logic [31:0] v;
        tx_tvalid = 1'b0;
        tx_tlast  = 1'b0;
        tx_tdata  = '0;
        errors    = 0;
        checks    = 0;
        idle_lfsr = 32'ha1ddf7f0;

        load_vectors(ok);
        for (int i = 0; i < 50 && !resetn; i++) begin
            @(posedge clk);
        end
        if (!resetn) begin
            report_error("reset was never released");
            ok = 1'b0;
        end

        if (ok) begin
            @(posedge clk);
            #1;

            // test 1
            e0 = errors;
            @(negedge clk);
            check_value("tx_en", 32'(tx_en), 32'h0);
            check_value("tx_er", 32'(tx_er), 32'h0);
            check_value("tx_tready", 32'(tx_tready), 32'h0);
            @(posedge clk);
            #1;
            $display("test 1 reset state: %0d errors", errors - e0);

            // test 2, every vector with random idle time
            e0 = errors;
            fork
                begin
                    foreach (v_len[i]) begin
                        take_bits(idle_lfsr, 3, v);
                        send_frame(i, int'(v));
                    end
                end
                check_frames(v_len.size());
            join
            $display("test 2 framing, padding, fcs and abort: %0d errors", errors - e0);

            // test 3, complete frames with no idle time
            e0 = errors;
            n_plain = 0;
            foreach (v_abort[i]) begin
                if (v_abort[i] < 0) begin
                    n_plain++;
                end
            end
            @(posedge clk);
            #1;
            fork
                begin
                    foreach (v_len[i]) begin
                        if (v_abort[i] < 0) begin
                            send_frame(i, 0);
                        end
                    end
                end
                check_frames(n_plain);
            join
            $display("test 3 back-to-back frames: %0d errors", errors - e0);
        end

        $display("tests 3, checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

//--- eth_tx_mac.f
eth_frame_pkg.sv
tx_ctrl_pkg.sv
tx_framer.sv
fcs_inserter.sv
eth_tx_mac.sv
tb_clock_gen.sv
tb_eth_tx_mac.sv

//--- Makefile
FILELIST = eth_tx_mac.f

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f $(FILELIST) --top-module eth_tx_mac
	verilator --lint-only --timing --assert -f $(FILELIST) --top-module tb_eth_tx_mac

sim:
	verilator --binary --timing --assert -j 0 -f $(FILELIST) \
		--top-module tb_eth_tx_mac -o Vtb_eth_tx_mac
	./obj_dir/Vtb_eth_tx_mac | tee sim.log
	@if grep -q "ERRORS FOUND" sim.log; then exit 1; fi
	@grep -q "NO ERRORS" sim.log

clean:
	rm -rf obj_dir sim.log

//--- eth_tx_vectors.txt
# payload_len abort_index(-1 = none) payload_seed(hex) expected_fcs(hex, 0 = not recorded)
# length/type bytes carry payload_len; payload bytes come from the lfsr with payload_seed
60 -1 1f2e3d4c 00000000
10 -1 5a5a0001 00000000
46 -1 00c0ffee 00000000
47 -1 13572468 00000000
45 -1 0badf00d 00000000
1 -1 00000001 00000000
60 20 2468ace0 00000000
64 -1 77665544 00000000
10 3 31415926 00000000
100 -1 deadbeef 00000000
100 0 cafebabe 00000000
2 -1 12345678 00000000
128 -1 0f0f0f0f 00000000
33 32 abcdef01 00000000
15 -1 55aa55aa 00000000
200 -1 87654321 00000000
61 -1 11223344 00000000
50 49 99887766 00000000
150 -1 feedface 00000000
20 -1 6b8b4567 00000000
3 -1 00abcdef 00000000
80 -1 327b23c6 00000000
